// ==== source/capture_config.svh ====
// Capture buffer widths

`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// Memory address width, which sets the length of the capture window
`define CAPTURE_ADDRESS_WIDTH 5

// Number of beats held in one capture window
`define CAPTURE_DEPTH (1 << `CAPTURE_ADDRESS_WIDTH)

// Field widths of one stream beat
`define CAPTURE_DATA_WIDTH 32
`define CAPTURE_DEST_WIDTH 16
`define CAPTURE_USER_WIDTH 16

`endif

// ==== source/stream_pkg.sv ====
// Stream beat types

`default_nettype none

`include "capture_config.svh"

package stream_pkg;

    // One beat of the input or output stream
    // The last flag only has meaning on the output side
    typedef struct packed {
        logic [`CAPTURE_DATA_WIDTH-1:0] data;
        logic [`CAPTURE_DEST_WIDTH-1:0] dest;
        logic [`CAPTURE_USER_WIDTH-1:0] user;
        logic                           last;
    } stream_beat_t;

endpackage

`default_nettype wire

// ==== source/capture_pkg.sv ====
// Capture engine types

`default_nettype none

`include "capture_config.svh"

package capture_pkg;

    // Capture FSM states
    typedef enum logic [1:0] {
        IDLE,
        PRE_TRIGGER,
        POST_TRIGGER,
        READOUT
    } capture_state_t;

    // Word kept in the capture memory
    // The last flag is rebuilt on readout, so it is not stored
    typedef struct packed {
        logic [`CAPTURE_DATA_WIDTH-1:0] data;
        logic [`CAPTURE_DEST_WIDTH-1:0] dest;
        logic [`CAPTURE_USER_WIDTH-1:0] user;
    } stored_word_t;

endpackage

`default_nettype wire

// ==== source/capture_memory.sv ====
// Capture memory

`timescale 1ns/100ps
`default_nettype none

`include "capture_config.svh"

module capture_memory (
    input  wire                                    clock,
    input  wire                                    wr_en,
    input  wire [`CAPTURE_ADDRESS_WIDTH-1:0]       wr_addr,
    input  wire capture_pkg::stored_word_t         wr_word,
    input  wire                                    rd_en,
    input  wire [`CAPTURE_ADDRESS_WIDTH-1:0]       rd_addr,
    output capture_pkg::stored_word_t              rd_word
);

    capture_pkg::stored_word_t mem [`CAPTURE_DEPTH];

    // Write port, one word per accepted input beat
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Registered read port, the word shows up one cycle after rd_en
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/capture_controller.sv ====
// Capture controller

`timescale 1ns/100ps
`default_nettype none

`include "capture_config.svh"

module capture_controller (
    input  wire                                    clock,
    input  wire                                    arst_n,
    input  wire                                    enable,
    input  wire                                    trigger,
    input  wire [`CAPTURE_ADDRESS_WIDTH-1:0]       trigger_point,
    input  wire                                    in_valid,
    input  wire stream_pkg::stream_beat_t          in_beat,
    output logic                                   in_ready,
    output logic                                   full,
    output logic                                   wr_en,
    output logic [`CAPTURE_ADDRESS_WIDTH-1:0]      wr_addr,
    output capture_pkg::stored_word_t              wr_word,
    output logic                                   start,
    output logic [`CAPTURE_ADDRESS_WIDTH-1:0]      start_addr,
    input  wire                                    done
);

    capture_pkg::capture_state_t state;

    logic [`CAPTURE_ADDRESS_WIDTH-1:0] wr_ptr;

    // Beats written since arming, held at the largest trigger point
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] pre_count;
    logic [`CAPTURE_ADDRESS_WIDTH:0]   pre_total;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] pre_next;

    // Post-trigger progress and the count latched when the trigger was taken
    logic [`CAPTURE_ADDRESS_WIDTH:0]   post_count;
    logic [`CAPTURE_ADDRESS_WIDTH:0]   post_target;
    logic [`CAPTURE_ADDRESS_WIDTH:0]   post_target_next;

    logic accept;
    logic trigger_taken;
    logic last_post_beat;

    // Input is only closed while the window is being replayed
    assign in_ready = enable && (state != capture_pkg::READOUT);
    assign accept   = in_valid && in_ready;

    // Every accepted beat goes straight into memory at the write pointer
    assign wr_en   = accept;
    assign wr_addr = wr_ptr;
    assign wr_word = '{data: in_beat.data, dest: in_beat.dest, user: in_beat.user};

    // After the last write the pointer sits on the oldest word of the window
    assign start_addr = wr_ptr;

    // A beat taken at the same edge as the trigger counts before it
    assign pre_total = {1'b0, pre_count} + {{`CAPTURE_ADDRESS_WIDTH{1'b0}}, accept};
    assign pre_next  = pre_total[`CAPTURE_ADDRESS_WIDTH] ?
                       {`CAPTURE_ADDRESS_WIDTH{1'b1}} :
                       pre_total[`CAPTURE_ADDRESS_WIDTH-1:0];

    assign trigger_taken = trigger && enable &&
                           (state == capture_pkg::PRE_TRIGGER) &&
                           (pre_total >= {1'b0, trigger_point});

    // Window length minus the beats kept from before the trigger
    assign post_target_next = {1'b1, {`CAPTURE_ADDRESS_WIDTH{1'b0}}} - {1'b0, trigger_point};

    assign last_post_beat = (state == capture_pkg::POST_TRIGGER) && accept &&
                            (post_count + 1'b1 == post_target);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= capture_pkg::IDLE;
            wr_ptr      <= '0;
            pre_count   <= '0;
            post_count  <= '0;
            post_target <= '0;
            full        <= 1'b0;
            start       <= 1'b0;
        end else begin
            start <= 1'b0;

            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            case (state)
                capture_pkg::IDLE: begin
                    // pre_count is zero here, so a beat taken now is the first one
                    if (enable) begin
                        state     <= capture_pkg::PRE_TRIGGER;
                        pre_count <= pre_next;
                    end
                end

                capture_pkg::PRE_TRIGGER: begin
                    if (!enable) begin
                        state     <= capture_pkg::IDLE;
                        pre_count <= '0;
                    end else begin
                        pre_count <= pre_next;
                        if (trigger_taken) begin
                            state       <= capture_pkg::POST_TRIGGER;
                            post_count  <= '0;
                            post_target <= post_target_next;
                        end
                    end
                end

                capture_pkg::POST_TRIGGER: begin
                    if (!enable) begin
                        state     <= capture_pkg::IDLE;
                        pre_count <= '0;
                    end else if (last_post_beat) begin
                        state <= capture_pkg::READOUT;
                        full  <= 1'b1;
                        start <= 1'b1;
                    end else if (accept) begin
                        post_count <= post_count + 1'b1;
                    end
                end

                capture_pkg::READOUT: begin
                    // Replay always runs to the end, then the buffer re-arms
                    if (done) begin
                        state     <= capture_pkg::PRE_TRIGGER;
                        full      <= 1'b0;
                        pre_count <= '0;
                    end
                end

                default: begin
                    state <= capture_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/capture_readout.sv ====
// Capture window readout

`timescale 1ns/100ps
`default_nettype none

`include "capture_config.svh"

module capture_readout (
    input  wire                                    clock,
    input  wire                                    arst_n,
    input  wire                                    start,
    input  wire [`CAPTURE_ADDRESS_WIDTH-1:0]       start_addr,
    input  wire                                    out_ready,
    output logic                                   rd_en,
    output logic [`CAPTURE_ADDRESS_WIDTH-1:0]      rd_addr,
    input  wire capture_pkg::stored_word_t         rd_word,
    output logic                                   out_valid,
    output stream_pkg::stream_beat_t               out_beat,
    output logic                                   done
);

    logic                              reading;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] rd_ptr;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] rd_remaining;

    // Read issued last cycle, its word is on rd_word now
    logic rd_pending;
    logic rd_pending_last;

    // Second buffer entry behind the output register
    logic                     skid_valid;
    stream_pkg::stream_beat_t skid_beat;
    stream_pkg::stream_beat_t landing_beat;

    logic       pop;
    logic       head_free;
    logic       load_head_from_skid;
    logic       load_head_from_read;
    logic       load_skid;
    logic [1:0] occupancy;
    logic [1:0] occupancy_next;

    assign landing_beat = '{
        data: rd_word.data,
        dest: rd_word.dest,
        user: rd_word.user,
        last: rd_pending_last
    };

    assign pop       = out_valid && out_ready;
    assign head_free = pop || !out_valid;

    // Entries still held at the end of this cycle, counting the word now landing
    assign occupancy      = {1'b0, out_valid} + {1'b0, skid_valid};
    assign occupancy_next = occupancy + {1'b0, rd_pending} - {1'b0, pop};

    // The first read goes out with start, later ones only if the word will fit
    assign rd_en   = start || (reading && (occupancy_next < 2'd2));
    assign rd_addr = start ? start_addr : rd_ptr;

    assign load_head_from_skid = head_free && skid_valid;
    assign load_head_from_read = head_free && !skid_valid && rd_pending;
    assign load_skid           = rd_pending && !load_head_from_read;

    assign done = pop && out_beat.last;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reading         <= 1'b0;
            rd_ptr          <= '0;
            rd_remaining    <= '0;
            rd_pending      <= 1'b0;
            rd_pending_last <= 1'b0;
            out_valid       <= 1'b0;
            skid_valid      <= 1'b0;
        end else begin
            rd_pending <= rd_en;

            if (start) begin
                // The word at start_addr is read now, the rest follow
                reading         <= 1'b1;
                rd_ptr          <= start_addr + 1'b1;
                rd_remaining    <= {`CAPTURE_ADDRESS_WIDTH{1'b1}};
                rd_pending_last <= 1'b0;
            end else if (rd_en) begin
                rd_ptr          <= rd_ptr + 1'b1;
                rd_remaining    <= rd_remaining - 1'b1;
                rd_pending_last <= (rd_remaining == 1);
                if (rd_remaining == 1) begin
                    reading <= 1'b0;
                end
            end

            if (head_free) begin
                out_valid <= skid_valid || rd_pending;
            end

            if (load_skid) begin
                skid_valid <= 1'b1;
            end else if (load_head_from_skid) begin
                skid_valid <= 1'b0;
            end
        end
    end

    // Beat payloads follow the valid flags above
    always_ff @(posedge clock) begin
        if (load_head_from_skid) begin
            out_beat <= skid_beat;
        end else if (load_head_from_read) begin
            out_beat <= landing_beat;
        end

        if (load_skid) begin
            skid_beat <= landing_beat;
        end
    end

endmodule

`default_nettype wire

// ==== source/ultra_buffer.sv ====
// Triggered capture buffer

`timescale 1ns/100ps
`default_nettype none

`include "capture_config.svh"

module ultra_buffer (
    input  wire                                    clock,
    input  wire                                    arst_n,
    input  wire                                    enable,
    input  wire                                    trigger,
    input  wire [`CAPTURE_ADDRESS_WIDTH-1:0]       trigger_point,
    output logic                                   full,
    input  wire                                    in_valid,
    output logic                                   in_ready,
    input  wire stream_pkg::stream_beat_t          in_beat,
    output logic                                   out_valid,
    input  wire                                    out_ready,
    output stream_pkg::stream_beat_t               out_beat
);

    logic                              wr_en;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] wr_addr;
    capture_pkg::stored_word_t         wr_word;

    logic                              rd_en;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] rd_addr;
    capture_pkg::stored_word_t         rd_word;

    logic                              start;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] start_addr;
    logic                              done;

    capture_controller controller (
        .clock         (clock),
        .arst_n        (arst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .in_valid      (in_valid),
        .in_beat       (in_beat),
        .in_ready      (in_ready),
        .full          (full),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .start         (start),
        .start_addr    (start_addr),
        .done          (done)
    );

    capture_memory memory (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_word (wr_word),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    capture_readout readout (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start),
        .start_addr (start_addr),
        .out_ready  (out_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_word    (rd_word),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== verif/ultra_buffer_tb.sv ====
// Capture buffer testbench

`timescale 1ns/100ps
`default_nettype none

`include "capture_config.svh"

module ultra_buffer_tb;

    localparam int COLUMNS   = 7;
    localparam int MAX_TESTS = 32;

    logic                              clock;
    logic                              arst_n;
    logic                              enable;
    logic                              trigger;
    logic [`CAPTURE_ADDRESS_WIDTH-1:0] trigger_point;
    logic                              full;
    logic                              in_valid;
    logic                              in_ready;
    stream_pkg::stream_beat_t          in_beat;
    logic                              out_valid;
    logic                              out_ready;
    stream_pkg::stream_beat_t          out_beat;

    // Golden rows with COLUMNS words per test
    logic [31:0] golden [COLUMNS*MAX_TESTS];

    int seed;
    int test_count;
    int cycle_count;
    int cycle_limit;

    // Fields of the test now running
    int                             tp;
    int                             pre;
    int                             early;
    logic [31:0]                    base;
    logic [`CAPTURE_DEST_WIDTH-1:0] dest;
    logic [`CAPTURE_USER_WIDTH-1:0] user;
    logic                           stall;

    ultra_buffer dut (
        .clock         (clock),
        .arst_n        (arst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .full          (full),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_beat       (in_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_beat      (out_beat)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_run("The run hung and reached the cycle limit before all tests finished");
        end
    end

    task automatic stop_run(input string what);
        capture_pkg::capture_state_t state_now;
        state_now = dut.controller.state;
        $display("%s", what);
        $display("Capture FSM was in state %s", state_now.name());
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_run($sformatf("** Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_beat(input string name, input stream_pkg::stream_beat_t actual,
                              input stream_pkg::stream_beat_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("** Error: %s is %h, expected %h (data %h dest %h user %h last %h)",
                               name, actual, expected, expected.data, expected.dest,
                               expected.user, expected.last));
        end
    endtask

    // Beat k of the replay counted from the oldest
    function automatic stream_pkg::stream_beat_t expected_beat(input int k);
        stream_pkg::stream_beat_t beat;
        beat.data = base + pre - tp + k;
        beat.dest = dest;
        beat.user = user;
        beat.last = (k == `CAPTURE_DEPTH - 1);
        return beat;
    endfunction

    // A trigger rides on the beat that completes the count or gets a quiet cycle of its own
    function automatic bit fires_here(input int at, input int sent);
        if (stall || at == 0) begin
            return sent == at;
        end
        return sent == at - 1;
    endfunction

    task automatic hold_disabled(input int cycles);
        @(negedge clock);
        enable       = 1'b0;
        in_valid     = 1'b1;
        in_beat      = '1;
        in_beat.data = 32'hdead_beef;
        repeat (cycles) begin
            @(negedge clock);
            check_flag("in_ready", in_ready, 1'b0);
            check_flag("full", full, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
            trigger = !trigger;
        end
        @(negedge clock);
        enable   = 1'b1;
        in_valid = 1'b0;
        trigger  = 1'b0;
        // One quiet cycle lets IDLE move on to PRE_TRIGGER
        @(negedge clock);
        check_flag("in_ready", in_ready, 1'b1);
    endtask

    task automatic run_test(input int t);
        int total_in;
        int sent;
        int received;
        int rnd;
        bit expect_full;
        bit main_fired;
        bit early_fired;
        bit finished;
        bit fire;
        bit offer;

        tp    = int'(golden[t*COLUMNS]);
        pre   = int'(golden[t*COLUMNS+1]);
        early = int'(golden[t*COLUMNS+2]);
        base  = golden[t*COLUMNS+3];
        dest  = golden[t*COLUMNS+4][`CAPTURE_DEST_WIDTH-1:0];
        user  = golden[t*COLUMNS+5][`CAPTURE_USER_WIDTH-1:0];
        stall = golden[t*COLUMNS+6][0];

        total_in      = pre + `CAPTURE_DEPTH - tp;
        sent          = 0;
        received      = 0;
        expect_full   = 1'b0;
        main_fired    = 1'b0;
        early_fired   = (early == 0);
        finished      = 1'b0;
        trigger_point = tp[`CAPTURE_ADDRESS_WIDTH-1:0];

        while (!finished) begin
            @(negedge clock);
            check_flag("full", full, expect_full);
            check_flag("in_ready", in_ready, !expect_full);
            if (!expect_full) begin
                check_flag("out_valid", out_valid, 1'b0);
            end

            if (received == `CAPTURE_DEPTH) begin
                // Window fully replayed and the buffer has armed itself again
                finished = 1'b1;
                in_valid = 1'b0;
                trigger  = 1'b0;
            end else begin
                rnd       = $random(seed);
                out_ready = !(stall && rnd[1:0] == 2'b00);
                // A held beat must match the same expected value until it transfers
                if (out_valid) begin
                    check_beat("out_beat", out_beat, expected_beat(received));
                    if (out_ready) begin
                        received++;
                        if (received == `CAPTURE_DEPTH) begin
                            expect_full = 1'b0;
                        end
                    end
                end

                fire  = 1'b0;
                rnd   = $random(seed);
                offer = !(stall && rnd[1:0] == 2'b00);
                if (!main_fired && fires_here(pre, sent)) begin
                    main_fired = 1'b1;
                    fire       = 1'b1;
                    offer      = offer && (sent != pre);
                end
                if (!early_fired && fires_here(early, sent)) begin
                    early_fired = 1'b1;
                    fire        = 1'b1;
                    offer       = offer && (sent != early);
                end
                // The post-trigger count is latched, so trigger_point is free to wander
                if (main_fired && !fire) begin
                    trigger_point = rnd[`CAPTURE_ADDRESS_WIDTH+3:4];
                end

                // Offers keep coming while the replay runs and must not be taken
                trigger      = fire;
                in_valid     = offer;
                in_beat.data = base + sent;
                in_beat.dest = dest;
                in_beat.user = user;
                in_beat.last = sent[0];
                if (offer && in_ready) begin
                    sent++;
                    if (sent == total_in) begin
                        expect_full = 1'b1;
                    end
                end
            end
        end
    endtask

    initial begin
        seed          = 89578;
        cycle_limit   = 0;
        arst_n        = 1'b0;
        enable        = 1'b0;
        trigger       = 1'b0;
        trigger_point = '0;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_ready     = 1'b0;

        for (int i = 0; i < COLUMNS * MAX_TESTS; i++) begin
            golden[i] = '1;
        end
        $readmemh("verif/capture_golden.txt", golden);
        test_count = 0;
        while (test_count < MAX_TESTS && golden[test_count*COLUMNS] !== '1) begin
            test_count++;
        end
        if (test_count == 0) begin
            stop_run("The golden file holds no tests");
        end
        cycle_limit = test_count * 400 + 100;

        repeat (16) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        check_flag("full", full, 1'b0);
        check_flag("in_ready", in_ready, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);

        // Most tests follow the previous one straight after its re-arm
        for (int t = 0; t < test_count; t++) begin
            if (t % 4 == 0) begin
                hold_disabled(6);
            end
            run_test(t);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
// Packages first, then the design from the leaves up, then the testbench
+incdir+source
source/stream_pkg.sv
source/capture_pkg.sv
source/capture_memory.sv
source/capture_controller.sv
source/capture_readout.sv
source/ultra_buffer.sv
verif/ultra_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the capture buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module ultra_buffer_tb \
    -f files.f \
    -o ultra_buffer_sim \
    && ./obj_dir/ultra_buffer_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q -F '*** PASSED ***' sim.log && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }

// ==== verif/capture_golden.txt ====
// trigger_point pre_count early_trigger_at base dest user stall_mode
// All values in hex, one test per line
00 00 00 10000000 0001 00a1 0
0a 0a 00 20000000 0002 00b2 0
1f 1f 00 30000000 0003 00c3 0
1f 28 00 40000000 0004 00d4 0
0c 14 05 50000000 0005 00e5 0
1c 1e 1b 60000000 0006 00f6 1
00 03 00 70000000 beef cafe 1
0a 0c 01 fffffff0 ffff 8001 1
05 05 02 00001234 5a5a a5a5 0
1f 2a 10 9abc0000 0f0f f0f0 1
